//--- hdl/axi_pkg.sv
`default_nettype none

package axi_pkg;

  localparam int unsigned ADDR_W  = 32;
  localparam int unsigned DATA_W  = 32;
  localparam int unsigned STRB_W  = DATA_W / 8;
  localparam int unsigned ID_W    = 4;
  localparam int unsigned IDS_W   = 8;
  localparam int unsigned LEN_W   = 4;
  localparam int unsigned SIZE_W  = 3;
  localparam int unsigned BURST_W = 2;
  localparam int unsigned RESP_W  = 2;

  // ==========================================================================
  // Channel payloads, master side and slave side
  // ==========================================================================

  typedef struct packed {
    logic [ID_W-1:0]    id;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
    logic [SIZE_W-1:0]  size;
    logic [BURST_W-1:0] burst;
    logic               valid;
  } ar_req_t;

  typedef struct packed {
    logic [IDS_W-1:0]   id;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
    logic [SIZE_W-1:0]  size;
    logic [BURST_W-1:0] burst;
    logic               valid;
  } ars_req_t;

  // AW carries exactly the AR fields
  typedef ar_req_t  aw_req_t;
  typedef ars_req_t aws_req_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [RESP_W-1:0] resp;
    logic              last;
    logic              valid;
  } r_resp_t;

  typedef struct packed {
    logic [IDS_W-1:0]  id;
    logic [DATA_W-1:0] data;
    logic [RESP_W-1:0] resp;
    logic              last;
    logic              valid;
  } rs_resp_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
    logic              valid;
  } w_req_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [RESP_W-1:0] resp;
    logic              valid;
  } b_resp_t;

  typedef struct packed {
    logic [IDS_W-1:0]  id;
    logic [RESP_W-1:0] resp;
    logic              valid;
  } bs_resp_t;

  // ==========================================================================
  // ID widening toward slaves, narrowing back toward masters
  // ==========================================================================

  function automatic ars_req_t widen_addr(input ar_req_t m);
    ars_req_t s;
    s.id    = IDS_W'(m.id);
    s.addr  = m.addr;
    s.len   = m.len;
    s.size  = m.size;
    s.burst = m.burst;
    s.valid = m.valid;
    return s;
  endfunction

  function automatic r_resp_t narrow_r(input rs_resp_t s);
    r_resp_t m;
    m.id    = s.id[ID_W-1:0];
    m.data  = s.data;
    m.resp  = s.resp;
    m.last  = s.last;
    m.valid = s.valid;
    return m;
  endfunction

  function automatic b_resp_t narrow_b(input bs_resp_t s);
    b_resp_t m;
    m.id    = s.id[ID_W-1:0];
    m.resp  = s.resp;
    m.valid = s.valid;
    return m;
  endfunction

endpackage

`default_nettype wire

//--- hdl/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

  localparam int unsigned NUM_SLAVES = 3;
  localparam int unsigned SLV_IDX_W  = $clog2(NUM_SLAVES);

  localparam logic [SLV_IDX_W-1:0] SLV_ROM = 0;
  localparam logic [SLV_IDX_W-1:0] SLV_IM  = 1;
  localparam logic [SLV_IDX_W-1:0] SLV_DM  = 2;

  // ==========================================================================
  // Address windows
  // ==========================================================================

  // ROM is the bottom 8 KiB
  localparam int unsigned ROM_TAG_LSB = 13;
  localparam logic [axi_pkg::ADDR_W-ROM_TAG_LSB-1:0] ROM_TAG = '0;

  // IM and DM are 64 KiB windows keyed on the upper half
  localparam int unsigned WIN_TAG_LSB = 16;
  localparam logic [axi_pkg::ADDR_W-WIN_TAG_LSB-1:0] IM_TAG = 16'h0001;
  localparam logic [axi_pkg::ADDR_W-WIN_TAG_LSB-1:0] DM_TAG = 16'h0002;

  typedef struct packed {
    logic                 hit;
    logic [SLV_IDX_W-1:0] idx;
  } slave_sel_t;

  function automatic slave_sel_t decode_slave(input logic [axi_pkg::ADDR_W-1:0] addr);
    slave_sel_t sel;
    sel.hit = 1'b1;
    sel.idx = SLV_ROM;
    if (addr[axi_pkg::ADDR_W-1:ROM_TAG_LSB] == ROM_TAG) begin
      sel.idx = SLV_ROM;
    end else if (addr[axi_pkg::ADDR_W-1:WIN_TAG_LSB] == IM_TAG) begin
      sel.idx = SLV_IM;
    end else if (addr[axi_pkg::ADDR_W-1:WIN_TAG_LSB] == DM_TAG) begin
      sel.idx = SLV_DM;
    end else begin
      sel.hit = 1'b0;
    end
    return sel;
  endfunction

endpackage

`default_nettype wire

//--- hdl/turn_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module turn_arbiter #(
  parameter int unsigned IDLE_CNT_W = 3
) (
  input  wire  ACLK,
  input  wire  ARESET,
  input  wire  rd_busy,
  input  wire  wr_busy,
  input  wire  rd_done,
  input  wire  wr_done,
  output logic m1_turn
);

  logic                  bus_idle;
  logic [IDLE_CNT_W-1:0] idle_cnt;
  logic                  idle_expired;

  assign bus_idle     = !rd_busy && !wr_busy;
  assign idle_expired = bus_idle && (&idle_cnt);

  // Idle cycles since either router last held the bus
  always_ff @(posedge ACLK or posedge ARESET) begin
    if (ARESET) begin
      idle_cnt <= '0;
    end else if (bus_idle) begin
      idle_cnt <= idle_cnt + 1'b1;
    end else begin
      idle_cnt <= '0;
    end
  end

  // Hand over after each completed transfer, or when the holder stays quiet
  always_ff @(posedge ACLK or posedge ARESET) begin
    if (ARESET) begin
      m1_turn <= 1'b0;
    end else if (rd_done || wr_done || idle_expired) begin
      m1_turn <= !m1_turn;
    end
  end

endmodule

`default_nettype wire

//--- hdl/read_router.sv
`timescale 1ns/1ps
`default_nettype none

module read_router (
  input  wire                                              ACLK,
  input  wire                                              ARESET,
  input  wire                                              m1_turn,
  input  axi_pkg::ar_req_t                                 m0_ar,
  output logic                                             m0_ar_ready,
  output axi_pkg::r_resp_t                                 m0_r,
  input  wire                                              m0_r_ready,
  input  axi_pkg::ar_req_t                                 m1_ar,
  output logic                                             m1_ar_ready,
  output axi_pkg::r_resp_t                                 m1_r,
  input  wire                                              m1_r_ready,
  output axi_pkg::ars_req_t [soc_map_pkg::NUM_SLAVES-1:0] s_ar,
  input  wire               [soc_map_pkg::NUM_SLAVES-1:0] s_ar_ready,
  input  axi_pkg::rs_resp_t [soc_map_pkg::NUM_SLAVES-1:0] s_r,
  output logic              [soc_map_pkg::NUM_SLAVES-1:0] s_r_ready,
  output logic                                             rd_busy,
  output logic                                             rd_done
);

  typedef enum logic [1:0] {
    IDLE,
    READ_M0,
    READ_M1
  } rd_state_t;

  rd_state_t                    state;
  rd_state_t                    state_d;
  logic [axi_pkg::ADDR_W-1:0]   addr_q;
  soc_map_pkg::slave_sel_t      sel;
  logic                         route;

  // Channels of whichever master holds the read path
  axi_pkg::ar_req_t             m_ar;
  logic                         m_r_ready;
  logic                         m_ar_ready;
  axi_pkg::r_resp_t             m_r;

  // ==========================================================================
  // FSM
  // ==========================================================================

  always_ff @(posedge ACLK or posedge ARESET) begin
    if (ARESET) begin
      state <= IDLE;
    end else begin
      state <= state_d;
    end
  end

  always_comb begin
    state_d = state;
    case (state)
      IDLE: begin
        if (!m1_turn && m0_ar.valid) begin
          state_d = READ_M0;
        end else if (m1_turn && m1_ar.valid) begin
          state_d = READ_M1;
        end
      end
      READ_M0, READ_M1: begin
        if (rd_done) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Address latched on the grant edge, decoded for the whole burst
  always_ff @(posedge ACLK) begin
    if (state == IDLE && state_d != IDLE) begin
      addr_q <= (state_d == READ_M1) ? m1_ar.addr : m0_ar.addr;
    end
  end

  assign sel = soc_map_pkg::decode_slave(addr_q);

  // ==========================================================================
  // Channel steering
  // ==========================================================================

  assign m_ar      = (state == READ_M1) ? m1_ar : m0_ar;
  assign m_r_ready = (state == READ_M1) ? m1_r_ready : m0_r_ready;

  // Instruction fetch has no path to DM
  assign route = (state != IDLE) && sel.hit &&
                 !(state == READ_M0 && sel.idx == soc_map_pkg::SLV_DM);

  always_comb begin
    s_ar       = '0;
    s_r_ready  = '0;
    m_ar_ready = 1'b0;
    m_r        = '0;
    if (route) begin
      s_ar[sel.idx]      = axi_pkg::widen_addr(m_ar);
      s_r_ready[sel.idx] = m_r_ready;
      m_ar_ready         = s_ar_ready[sel.idx];
      m_r                = axi_pkg::narrow_r(s_r[sel.idx]);
    end
  end

  assign m0_ar_ready = (state == READ_M0) && m_ar_ready;
  assign m1_ar_ready = (state == READ_M1) && m_ar_ready;
  assign m0_r        = (state == READ_M0) ? m_r : '0;
  assign m1_r        = (state == READ_M1) ? m_r : '0;

  assign rd_busy = (state != IDLE);
  assign rd_done = m_r.valid && m_r.last && m_r_ready;

endmodule

`default_nettype wire

//--- hdl/write_router.sv
`timescale 1ns/1ps
`default_nettype none

module write_router (
  input  wire                                              ACLK,
  input  wire                                              ARESET,
  input  wire                                              m1_turn,
  input  axi_pkg::aw_req_t                                 m1_aw,
  output logic                                             m1_aw_ready,
  input  axi_pkg::w_req_t                                  m1_w,
  output logic                                             m1_w_ready,
  output axi_pkg::b_resp_t                                 m1_b,
  input  wire                                              m1_b_ready,
  output axi_pkg::aws_req_t [soc_map_pkg::NUM_SLAVES-1:0] s_aw,
  input  wire               [soc_map_pkg::NUM_SLAVES-1:0] s_aw_ready,
  output axi_pkg::w_req_t   [soc_map_pkg::NUM_SLAVES-1:0] s_w,
  input  wire               [soc_map_pkg::NUM_SLAVES-1:0] s_w_ready,
  input  axi_pkg::bs_resp_t [soc_map_pkg::NUM_SLAVES-1:0] s_b,
  output logic              [soc_map_pkg::NUM_SLAVES-1:0] s_b_ready,
  output logic                                             wr_busy,
  output logic                                             wr_done
);

  typedef enum logic {
    IDLE,
    WRITE
  } wr_state_t;

  wr_state_t                  state;
  wr_state_t                  state_d;
  logic [axi_pkg::ADDR_W-1:0] addr_q;
  soc_map_pkg::slave_sel_t    sel;
  logic                       route;

  always_ff @(posedge ACLK or posedge ARESET) begin
    if (ARESET) begin
      state <= IDLE;
    end else begin
      state <= state_d;
    end
  end

  always_comb begin
    state_d = state;
    case (state)
      IDLE:    if (m1_turn && m1_aw.valid) state_d = WRITE;
      WRITE:   if (wr_done) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge ACLK) begin
    if (state == IDLE && state_d == WRITE) begin
      addr_q <= m1_aw.addr;
    end
  end

  assign sel = soc_map_pkg::decode_slave(addr_q);

  // ==========================================================================
  // Steering, ROM is never a write target
  // ==========================================================================

  assign route = (state == WRITE) && sel.hit && (sel.idx != soc_map_pkg::SLV_ROM);

  always_comb begin
    s_aw        = '0;
    s_w         = '0;
    s_b_ready   = '0;
    m1_aw_ready = 1'b0;
    m1_w_ready  = 1'b0;
    m1_b        = '0;
    if (route) begin
      s_aw[sel.idx]      = axi_pkg::widen_addr(m1_aw);
      s_w[sel.idx]       = m1_w;
      s_b_ready[sel.idx] = m1_b_ready;
      m1_aw_ready        = s_aw_ready[sel.idx];
      m1_w_ready         = s_w_ready[sel.idx];
      m1_b               = axi_pkg::narrow_b(s_b[sel.idx]);
    end
  end

  assign wr_busy = (state == WRITE);
  assign wr_done = m1_b.valid && m1_b_ready;

endmodule

`default_nettype wire

//--- hdl/axi_crossbar.sv
`timescale 1ns/1ps
`default_nettype none

module axi_crossbar #(
  parameter int unsigned IDLE_CNT_W = 3
) (
  input  wire                                              ACLK,
  input  wire                                              ARESET,
  // Master 0, instruction fetch
  input  axi_pkg::ar_req_t                                 m0_ar,
  output logic                                             m0_ar_ready,
  output axi_pkg::r_resp_t                                 m0_r,
  input  wire                                              m0_r_ready,
  // Master 1, data access
  input  axi_pkg::ar_req_t                                 m1_ar,
  output logic                                             m1_ar_ready,
  output axi_pkg::r_resp_t                                 m1_r,
  input  wire                                              m1_r_ready,
  input  axi_pkg::aw_req_t                                 m1_aw,
  output logic                                             m1_aw_ready,
  input  axi_pkg::w_req_t                                  m1_w,
  output logic                                             m1_w_ready,
  output axi_pkg::b_resp_t                                 m1_b,
  input  wire                                              m1_b_ready,
  // Slaves, indexed by soc_map_pkg slave number
  output axi_pkg::ars_req_t [soc_map_pkg::NUM_SLAVES-1:0] s_ar,
  input  wire               [soc_map_pkg::NUM_SLAVES-1:0] s_ar_ready,
  input  axi_pkg::rs_resp_t [soc_map_pkg::NUM_SLAVES-1:0] s_r,
  output logic              [soc_map_pkg::NUM_SLAVES-1:0] s_r_ready,
  output axi_pkg::aws_req_t [soc_map_pkg::NUM_SLAVES-1:0] s_aw,
  input  wire               [soc_map_pkg::NUM_SLAVES-1:0] s_aw_ready,
  output axi_pkg::w_req_t   [soc_map_pkg::NUM_SLAVES-1:0] s_w,
  input  wire               [soc_map_pkg::NUM_SLAVES-1:0] s_w_ready,
  input  axi_pkg::bs_resp_t [soc_map_pkg::NUM_SLAVES-1:0] s_b,
  output logic              [soc_map_pkg::NUM_SLAVES-1:0] s_b_ready
);

  logic m1_turn;
  logic rd_busy;
  logic rd_done;
  logic wr_busy;
  logic wr_done;

  turn_arbiter #(
    .IDLE_CNT_W (IDLE_CNT_W)
  ) u_turn_arbiter (
    .ACLK    (ACLK),
    .ARESET  (ARESET),
    .rd_busy (rd_busy),
    .wr_busy (wr_busy),
    .rd_done (rd_done),
    .wr_done (wr_done),
    .m1_turn (m1_turn)
  );

  read_router u_read_router (
    .ACLK        (ACLK),
    .ARESET      (ARESET),
    .m1_turn     (m1_turn),
    .m0_ar       (m0_ar),
    .m0_ar_ready (m0_ar_ready),
    .m0_r        (m0_r),
    .m0_r_ready  (m0_r_ready),
    .m1_ar       (m1_ar),
    .m1_ar_ready (m1_ar_ready),
    .m1_r        (m1_r),
    .m1_r_ready  (m1_r_ready),
    .s_ar        (s_ar),
    .s_ar_ready  (s_ar_ready),
    .s_r         (s_r),
    .s_r_ready   (s_r_ready),
    .rd_busy     (rd_busy),
    .rd_done     (rd_done)
  );

  write_router u_write_router (
    .ACLK        (ACLK),
    .ARESET      (ARESET),
    .m1_turn     (m1_turn),
    .m1_aw       (m1_aw),
    .m1_aw_ready (m1_aw_ready),
    .m1_w        (m1_w),
    .m1_w_ready  (m1_w_ready),
    .m1_b        (m1_b),
    .m1_b_ready  (m1_b_ready),
    .s_aw        (s_aw),
    .s_aw_ready  (s_aw_ready),
    .s_w         (s_w),
    .s_w_ready   (s_w_ready),
    .s_b         (s_b),
    .s_b_ready   (s_b_ready),
    .wr_busy     (wr_busy),
    .wr_done     (wr_done)
  );

endmodule

`default_nettype wire

//--- tb/tb_slave_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_slave_mem #(
  parameter int unsigned SLV_IDX   = 0,
  parameter logic [31:0] BASE      = 32'h0,
  parameter int unsigned READY_DLY = 1
) (
  input  wire                ACLK,
  input  wire                ARESET,
  input  axi_pkg::ars_req_t  ar,
  output logic               ar_ready,
  output axi_pkg::rs_resp_t  r,
  input  wire                r_ready,
  input  axi_pkg::aws_req_t  aw,
  output logic               aw_ready,
  input  axi_pkg::w_req_t    w,
  output logic               w_ready,
  output axi_pkg::bs_resp_t  b,
  input  wire                b_ready
);

  // 8 KiB per slave, enough for every window under test
  localparam int unsigned WORDS = 2048;

  logic [31:0] mem [WORDS];
  logic [31:0] rd_addr;
  logic [31:0] wr_addr;
  logic [3:0]  rd_beat;
  logic [3:0]  rd_len;
  int unsigned ar_wait;
  int unsigned aw_wait;

  always_ff @(posedge ACLK or posedge ARESET) begin
    if (ARESET) begin
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= (BASE + 32'(4 * i)) ^ (32'(SLV_IDX) << 24);
      end
      ar_ready <= 1'b0;
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      r        <= '0;
      b        <= '0;
      rd_addr  <= '0;
      wr_addr  <= '0;
      rd_beat  <= '0;
      rd_len   <= '0;
      ar_wait  <= 0;
      aw_wait  <= 0;
    end else begin
      // ======================================================================
      // Read side
      // ======================================================================
      if (!r.valid && ar.valid && !ar_ready) begin
        if (ar_wait == READY_DLY) begin
          ar_ready <= 1'b1;
        end else begin
          ar_wait <= ar_wait + 1;
        end
      end
      if (ar.valid && ar_ready) begin
        ar_ready <= 1'b0;
        ar_wait  <= 0;
        r.valid  <= 1'b1;
        r.id     <= ar.id;
        r.resp   <= '0;
        r.data   <= mem[ar.addr[12:2]];
        r.last   <= (ar.len == 0);
        rd_addr  <= ar.addr + 32'd4;
        rd_beat  <= 4'd1;
        rd_len   <= ar.len;
      end else if (r.valid && r_ready) begin
        if (r.last) begin
          r.valid <= 1'b0;
          r.last  <= 1'b0;
        end else begin
          r.data  <= mem[rd_addr[12:2]];
          r.last  <= (rd_beat == rd_len);
          rd_addr <= rd_addr + 32'd4;
          rd_beat <= rd_beat + 1'b1;
        end
      end

      // ======================================================================
      // Write side
      // ======================================================================
      if (!w_ready && !b.valid && aw.valid && !aw_ready) begin
        if (aw_wait == READY_DLY) begin
          aw_ready <= 1'b1;
        end else begin
          aw_wait <= aw_wait + 1;
        end
      end
      if (aw.valid && aw_ready) begin
        aw_ready <= 1'b0;
        aw_wait  <= 0;
        wr_addr  <= aw.addr;
        b.id     <= aw.id;
        w_ready  <= 1'b1;
      end
      if (w.valid && w_ready) begin
        for (int k = 0; k < axi_pkg::STRB_W; k++) begin
          if (w.strb[k]) begin
            mem[wr_addr[12:2]][8*k +: 8] <= w.data[8*k +: 8];
          end
        end
        wr_addr <= wr_addr + 32'd4;
        if (w.last) begin
          w_ready <= 1'b0;
          b.valid <= 1'b1;
          b.resp  <= '0;
        end
      end
      if (b.valid && b_ready) begin
        b.valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/crossbar_checker.sv
`timescale 1ns/1ps
`default_nettype none

module crossbar_checker (
  input wire                                              ACLK,
  input wire                                              ARESET,
  input axi_pkg::ars_req_t [soc_map_pkg::NUM_SLAVES-1:0] s_ar,
  input axi_pkg::aws_req_t [soc_map_pkg::NUM_SLAVES-1:0] s_aw,
  input axi_pkg::r_resp_t                                 m0_r,
  input wire                                              m0_r_ready,
  input axi_pkg::r_resp_t                                 m1_r,
  input wire                                              m1_r_ready,
  input axi_pkg::b_resp_t                                 m1_b,
  input wire                                              m1_b_ready
);

  bit assert_failed = 1'b0;

  // Slave index by window, -1 outside every window
  function automatic int window_of(input logic [31:0] addr);
    if (addr < 32'h2000) return 0;
    if (addr[31:16] == 16'h0001) return 1;
    if (addr[31:16] == 16'h0002) return 2;
    return -1;
  endfunction

  a_ar_onehot: assert property (@(posedge ACLK) disable iff (ARESET)
    $onehot0({s_ar[2].valid, s_ar[1].valid, s_ar[0].valid}))
    else begin
      $error("ar valid at several slaves");
      assert_failed = 1'b1;
    end

  a_aw_onehot: assert property (@(posedge ACLK) disable iff (ARESET)
    $onehot0({s_aw[2].valid, s_aw[1].valid, s_aw[0].valid}))
    else begin
      $error("aw valid at several slaves");
      assert_failed = 1'b1;
    end

  a_rom_no_aw: assert property (@(posedge ACLK) disable iff (ARESET) !s_aw[0].valid)
    else begin
      $error("aw valid toward ROM");
      assert_failed = 1'b1;
    end

  a_r_exclusive: assert property (@(posedge ACLK) disable iff (ARESET)
    !(m0_r.valid && m1_r.valid))
    else begin
      $error("both masters see r valid");
      assert_failed = 1'b1;
    end

  for (genvar i = 0; i < soc_map_pkg::NUM_SLAVES; i++) begin : g_slv
    a_ar_route: assert property (@(posedge ACLK) disable iff (ARESET)
      s_ar[i].valid |-> window_of(s_ar[i].addr) == i)
      else begin
        $error("ar routed to wrong slave");
        assert_failed = 1'b1;
      end
    a_aw_route: assert property (@(posedge ACLK) disable iff (ARESET)
      s_aw[i].valid |-> window_of(s_aw[i].addr) == i)
      else begin
        $error("aw routed to wrong slave");
        assert_failed = 1'b1;
      end
  end

  // Stalled beats hold until accepted
  a_m0_r_hold: assert property (@(posedge ACLK) disable iff (ARESET)
    m0_r.valid && !m0_r_ready |=> $stable(m0_r))
    else begin
      $error("m0 r beat changed under stall");
      assert_failed = 1'b1;
    end

  a_m1_r_hold: assert property (@(posedge ACLK) disable iff (ARESET)
    m1_r.valid && !m1_r_ready |=> $stable(m1_r))
    else begin
      $error("m1 r beat changed under stall");
      assert_failed = 1'b1;
    end

  a_m1_b_hold: assert property (@(posedge ACLK) disable iff (ARESET)
    m1_b.valid && !m1_b_ready |=> $stable(m1_b))
    else begin
      $error("m1 b response changed under stall");
      assert_failed = 1'b1;
    end

endmodule

bind axi_crossbar crossbar_checker u_checker (
  .ACLK       (ACLK),
  .ARESET     (ARESET),
  .s_ar       (s_ar),
  .s_aw       (s_aw),
  .m0_r       (m0_r),
  .m0_r_ready (m0_r_ready),
  .m1_r       (m1_r),
  .m1_r_ready (m1_r_ready),
  .m1_b       (m1_b),
  .m1_b_ready (m1_b_ready)
);

`default_nettype wire

//--- tb/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  localparam int unsigned IDLE_CNT_W  = 3;
  localparam int unsigned NS          = soc_map_pkg::NUM_SLAVES;
  localparam int unsigned TIMEOUT     = 200;
  // Longest wait for an idle handover to master 1
  localparam int unsigned GRANT_LIMIT = (1 << IDLE_CNT_W) + 2;

  logic ACLK = 1'b0;
  logic ARESET;

  axi_pkg::ar_req_t  m0_ar;
  logic              m0_ar_ready;
  axi_pkg::r_resp_t  m0_r;
  logic              m0_r_ready;
  axi_pkg::ar_req_t  m1_ar;
  logic              m1_ar_ready;
  axi_pkg::r_resp_t  m1_r;
  logic              m1_r_ready;
  axi_pkg::aw_req_t  m1_aw;
  logic              m1_aw_ready;
  axi_pkg::w_req_t   m1_w;
  logic              m1_w_ready;
  axi_pkg::b_resp_t  m1_b;
  logic              m1_b_ready;

  axi_pkg::ars_req_t [NS-1:0] s_ar;
  logic              [NS-1:0] s_ar_ready;
  axi_pkg::rs_resp_t [NS-1:0] s_r;
  logic              [NS-1:0] s_r_ready;
  axi_pkg::aws_req_t [NS-1:0] s_aw;
  logic              [NS-1:0] s_aw_ready;
  axi_pkg::w_req_t   [NS-1:0] s_w;
  logic              [NS-1:0] s_w_ready;
  axi_pkg::bs_resp_t [NS-1:0] s_b;
  logic              [NS-1:0] s_b_ready;

  logic [31:0] rng_state;
  int unsigned cycle_cnt = 0;
  int unsigned last_grant_cycle;
  int          grant_log[$];
  logic [31:0] shadow_addr[$];
  logic [31:0] shadow_data[$];

  always #20 ACLK = ~ACLK;

  always @(posedge ACLK) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  axi_crossbar #(
    .IDLE_CNT_W (IDLE_CNT_W)
  ) uut (
    .ACLK (ACLK), .ARESET (ARESET),
    .m0_ar (m0_ar), .m0_ar_ready (m0_ar_ready), .m0_r (m0_r), .m0_r_ready (m0_r_ready),
    .m1_ar (m1_ar), .m1_ar_ready (m1_ar_ready), .m1_r (m1_r), .m1_r_ready (m1_r_ready),
    .m1_aw (m1_aw), .m1_aw_ready (m1_aw_ready), .m1_w (m1_w), .m1_w_ready (m1_w_ready),
    .m1_b (m1_b), .m1_b_ready (m1_b_ready),
    .s_ar (s_ar), .s_ar_ready (s_ar_ready), .s_r (s_r), .s_r_ready (s_r_ready),
    .s_aw (s_aw), .s_aw_ready (s_aw_ready), .s_w (s_w), .s_w_ready (s_w_ready),
    .s_b (s_b), .s_b_ready (s_b_ready)
  );

  // ROM, IM and DM, each a 64 KiB window apart
  for (genvar i = 0; i < NS; i++) begin : g_mem
    tb_slave_mem #(
      .SLV_IDX   (i),
      .BASE      (32'(i) << 16),
      .READY_DLY (i + 1)
    ) u_mem (
      .ACLK (ACLK), .ARESET (ARESET),
      .ar (s_ar[i]), .ar_ready (s_ar_ready[i]), .r (s_r[i]), .r_ready (s_r_ready[i]),
      .aw (s_aw[i]), .aw_ready (s_aw_ready[i]), .w (s_w[i]), .w_ready (s_w_ready[i]),
      .b (s_b[i]), .b_ready (s_b_ready[i])
    );
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  function automatic logic [31:0] rand_next();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [31:0] rand_addr(input int slv);
    return (32'(slv) << 16) + ((rand_next() % 2032) << 2);
  endfunction

  // Slave that owns an address in the memory map
  function automatic int unsigned slave_of(input logic [31:0] addr);
    return (addr < 32'h2000) ? 0 : int'(addr[31:16]);
  endfunction

  // Last written value, else the reset fill of the owning slave
  function automatic logic [31:0] exp_word(input logic [31:0] addr);
    logic [31:0] idx;
    for (int i = shadow_addr.size() - 1; i >= 0; i--) begin
      if (shadow_addr[i] == addr) return shadow_data[i];
    end
    idx = slave_of(addr);
    return addr ^ (idx << 24);
  endfunction

  task automatic fail_stop();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    fail_stop();
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
    fail_stop();
  endtask

  task automatic read_burst(input int m, input logic [31:0] addr,
                            input logic [3:0] len, input logic [3:0] id);
    axi_pkg::ar_req_t req;
    axi_pkg::r_resp_t beat;
    logic             rdy;
    logic             done;
    logic             granted;
    int unsigned      slv;
    int unsigned      n;
    int unsigned      wait_cnt;
    req       = '0;
    req.id    = id;
    req.addr  = addr;
    req.len   = len;
    req.size  = 3'd2;
    req.burst = 2'b01;
    req.valid = 1'b1;
    @(posedge ACLK);
    #2;
    if (m == 0) m0_ar = req;
    else m1_ar = req;
    slv      = slave_of(addr);
    granted  = 1'b0;
    done     = 1'b0;
    wait_cnt = 0;
    while (!done) begin
      @(negedge ACLK);
      // Grant shows as the request reaching its slave
      if (!granted && s_ar[slv].valid && s_ar[slv].id == axi_pkg::IDS_W'(id)) begin
        granted          = 1'b1;
        last_grant_cycle = cycle_cnt;
      end
      if ((m == 0) ? m0_ar_ready : m1_ar_ready) begin
        done = 1'b1;
      end else begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT) report_timeout("read address ready");
      end
    end
    grant_log.push_back(m);
    @(posedge ACLK);
    #2;
    // First beat is held off for a cycle
    if (m == 0) begin
      m0_ar.valid = 1'b0;
      m0_r_ready  = 1'b0;
    end else begin
      m1_ar.valid = 1'b0;
      m1_r_ready  = 1'b0;
    end
    n        = 0;
    wait_cnt = 0;
    while (n <= len) begin
      @(negedge ACLK);
      beat = (m == 0) ? m0_r : m1_r;
      rdy  = (m == 0) ? m0_r_ready : m1_r_ready;
      if (beat.valid && rdy) begin
        assert (beat.data == exp_word(addr + 32'(4 * n)))
          else report_error($sformatf("m%0d read %h beat %0d data %h expected %h",
                                      m, addr, n, beat.data, exp_word(addr + 32'(4 * n))));
        assert (beat.id == id)
          else report_error($sformatf("m%0d read id %h expected %h", m, beat.id, id));
        assert (beat.last == (n == len))
          else report_error($sformatf("m%0d read last %b on beat %0d", m, beat.last, n));
        n++;
        wait_cnt = 0;
      end else begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT) report_timeout("read data beat");
      end
      @(posedge ACLK);
      #2;
      rdy = (n <= len) && ((rand_next() % 4) != 0);
      if (m == 0) m0_r_ready = rdy;
      else m1_r_ready = rdy;
    end
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [3:0] id);
    logic [31:0] merged;
    logic        done;
    int unsigned wait_cnt;
    merged = exp_word(addr);
    for (int k = 0; k < 4; k++) begin
      if (strb[k]) merged[8*k +: 8] = data[8*k +: 8];
    end
    @(posedge ACLK);
    #2;
    m1_aw       = '0;
    m1_aw.id    = id;
    m1_aw.addr  = addr;
    m1_aw.size  = 3'd2;
    m1_aw.burst = 2'b01;
    m1_aw.valid = 1'b1;
    done     = 1'b0;
    wait_cnt = 0;
    while (!done) begin
      @(negedge ACLK);
      done = m1_aw_ready;
      wait_cnt++;
      if (!done && wait_cnt > TIMEOUT) report_timeout("write address ready");
    end
    @(posedge ACLK);
    #2;
    m1_aw.valid = 1'b0;
    m1_w        = '{data: data, strb: strb, last: 1'b1, valid: 1'b1};
    done     = 1'b0;
    wait_cnt = 0;
    while (!done) begin
      @(negedge ACLK);
      done = m1_w_ready;
      wait_cnt++;
      if (!done && wait_cnt > TIMEOUT) report_timeout("write data ready");
    end
    @(posedge ACLK);
    #2;
    // Response is held off for a cycle
    m1_w       = '0;
    m1_b_ready = 1'b0;
    done     = 1'b0;
    wait_cnt = 0;
    while (!done) begin
      @(negedge ACLK);
      if (m1_b.valid && m1_b_ready) begin
        assert (m1_b.id == id)
          else report_error($sformatf("write response id %h expected %h", m1_b.id, id));
        done = 1'b1;
      end else begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT) report_timeout("write response");
      end
      @(posedge ACLK);
      #2;
      m1_b_ready = !done && ((rand_next() % 4) != 0);
    end
    shadow_addr.push_back(addr);
    shadow_data.push_back(merged);
  endtask

  // Bound assertion failures end the run at once
  always @(negedge ACLK) begin
    if (uut.u_checker.assert_failed) begin
      $display("A bound crossbar assertion failed during the run");
      fail_stop();
    end
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  initial begin
    logic [31:0] addr;
    int unsigned t0;
    rng_state  = 32'd21;
    ARESET     = 1'b1;
    m0_ar      = '0;
    m1_ar      = '0;
    m1_aw      = '0;
    m1_w       = '0;
    m0_r_ready = 1'b0;
    m1_r_ready = 1'b0;
    m1_b_ready = 1'b0;
    repeat (10) @(posedge ACLK);
    #2;
    ARESET = 1'b0;

    // Instruction fetch bursts from ROM and IM
    for (int k = 0; k < 4; k++) begin
      read_burst(0, rand_addr(0), 4'(rand_next() % 8), 4'(rand_next()));
      read_burst(0, rand_addr(1), 4'(rand_next() % 8), 4'(rand_next()));
    end

    // Strobed writes, read back by the data and the fetch master
    for (int k = 0; k < 3; k++) begin
      addr = rand_addr(2);
      write_word(addr, rand_next(), 4'(rand_next()), 4'(rand_next()));
      read_burst(1, addr, 4'd0, 4'(rand_next()));
      addr = rand_addr(1);
      write_word(addr, rand_next(), 4'(rand_next()), 4'(rand_next()));
      read_burst(0, addr, 4'd0, 4'(rand_next()));
    end

    // Both masters reading back to back
    grant_log.delete();
    fork
      for (int k = 0; k < 4; k++) begin
        read_burst(0, rand_addr(k % 2), 4'(rand_next() % 4), 4'(k));
      end
      for (int k = 0; k < 4; k++) begin
        read_burst(1, rand_addr(2 - (k % 3)), 4'(rand_next() % 4), 4'(k + 8));
      end
    join
    for (int i = 1; i < grant_log.size(); i++) begin
      assert (grant_log[i] != grant_log[i-1])
        else report_error($sformatf("grant %0d went to master %0d twice", i, grant_log[i]));
    end

    // Turn passes to master 0 after this read, then idles over to master 1
    read_burst(1, rand_addr(2), 4'd1, 4'd3);
    t0 = cycle_cnt;
    read_burst(1, rand_addr(1), 4'd1, 4'd5);
    assert (last_grant_cycle - t0 <= GRANT_LIMIT)
      else report_error($sformatf("idle handover took %0d cycles", last_grant_cycle - t0));

    repeat (4) @(posedge ACLK);
    if (!uut.u_checker.assert_failed) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("A bound crossbar assertion failed during the run");
      fail_stop();
    end
  end

endmodule

`default_nettype wire

//--- list.f
hdl/axi_pkg.sv
hdl/soc_map_pkg.sv
hdl/turn_arbiter.sv
hdl/read_router.sv
hdl/write_router.sv
hdl/axi_crossbar.sv
tb/tb_slave_mem.sv
tb/crossbar_checker.sv
tb/tb_top.sv

//--- Bender.yml
package:
  name: axi_crossbar

sources:
  - hdl/axi_pkg.sv
  - hdl/soc_map_pkg.sv
  - hdl/turn_arbiter.sv
  - hdl/read_router.sv
  - hdl/write_router.sv
  - hdl/axi_crossbar.sv
  - target: test
    files:
      - tb/tb_slave_mem.sv
      - tb/crossbar_checker.sv
      - tb/tb_top.sv
